// ==== hw/burst_pkg.sv ====
`default_nettype none

package burst_pkg;

   // controller state
   typedef enum logic [1:0] {
      IDLE   = 2'd0,  // no burst
      STREAM = 2'd1,  // accepting source words
      FLUSH  = 2'd2   // emitting the spill word
   } wr_state_t;

   // byte lane index width for a data width
   function automatic int lanes_w(input int data_w);
      return $clog2(data_w / 8);
   endfunction

endpackage

`default_nettype wire

// ==== hw/byte_realign.sv ====
`default_nettype none

module byte_realign #(
   parameter int DATA_W = 32
) (
   input  wire                                   clk_i,
   input  wire                                   rst_i,
   input  wire  [burst_pkg::lanes_w(DATA_W)-1:0] offset_i,
   input  wire  [DATA_W-1:0]                     data_i,
   input  wire                                   accept_i,
   output logic [DATA_W-1:0]                     data_o
);

   localparam int B = DATA_W / 8;

   logic [DATA_W-9:0]   prev_q;  // bytes 1..B-1 of last accepted word
   logic [2*DATA_W-9:0] joined;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         prev_q <= '0;
      end else if (accept_i) begin
         prev_q <= data_i[DATA_W-1:8];
      end
   end

   assign joined = {data_i, prev_q};

   // Lane i takes byte (i + B - 1 - offset) of the joined vector. Lanes at or
   // above the offset land in data_i, lanes below it in the held word.
   always_comb begin
      for (int i = 0; i < B; i++) begin
         data_o[8*i +: 8] = joined[8*(i + B - 1 - int'(offset_i)) +: 8];
      end
   end

endmodule

`default_nettype wire

// ==== hw/wr_strobe_gen.sv ====
`default_nettype none

module wr_strobe_gen #(
   parameter int DATA_W = 32
) (
   input  wire                                   first_i,
   input  wire                                   last_i,
   input  wire  [burst_pkg::lanes_w(DATA_W)-1:0] start_lane_i,
   input  wire  [burst_pkg::lanes_w(DATA_W)-1:0] end_lane_i,
   output logic [DATA_W/8-1:0]                   strb_o
);

   localparam int B = DATA_W / 8;

   logic [B-1:0] lo_mask;  // lanes from start lane up
   logic [B-1:0] hi_mask;  // lanes up to end lane

   always_comb begin
      for (int i = 0; i < B; i++) begin
         lo_mask[i] = (i >= int'(start_lane_i));
         hi_mask[i] = (i <= int'(end_lane_i));
      end
   end

   // single word burst gets both bounds
   assign strb_o = (first_i ? lo_mask : {B{1'b1}}) & (last_i ? hi_mask : {B{1'b1}});

endmodule

`default_nettype wire

// ==== hw/burst_write_ctrl.sv ====
`default_nettype none

module burst_write_ctrl #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 16,
   parameter int LEN_W  = 10
) (
   input  wire                                          clk_i,
   input  wire                                          rst_i,
   input  wire                                          start_i,
   input  wire  [ADDR_W-1:0]                            addr_i,
   input  wire  [LEN_W-1:0]                             len_i,
   input  wire                                          data_valid_i,
   input  wire  [DATA_W-1:0]                            data_i,
   output logic                                         mem_we_o,
   output logic [ADDR_W-burst_pkg::lanes_w(DATA_W)-1:0] mem_addr_o,
   output logic [DATA_W/8-1:0]                          mem_strb_o,
   output logic [DATA_W-1:0]                            mem_data_o,
   output logic                                         busy_o,
   output logic                                         done_o
);

   import burst_pkg::*;

   localparam int B    = DATA_W / 8;
   localparam int LW   = lanes_w(DATA_W);
   localparam int WA_W = ADDR_W - LW;
   localparam int WC_W = LEN_W - LW;

   wr_state_t         state_q;
   wr_state_t         state_d;
   logic [LW-1:0]     offset_q;
   logic [LW-1:0]     end_lane_q;
   logic [WA_W-1:0]   waddr_q;
   logic [WC_W-1:0]   words_left_q;  // source words after the current one
   logic              flush_q;       // burst spills into one more word
   logic              first_q;
   logic              done_q;

   logic [LEN_W-1:0]  len_m1;
   logic [LW:0]       spill_sum;
   logic              take_start;
   logic              accept;
   logic              flush_fire;
   logic              last_src;
   logic              last_wr;       // final memory word of the burst
   logic              wr_fire;
   logic [DATA_W-1:0] realigned;
   logic [B-1:0]      strb;

   // carry out of offset + last source lane means a flush word
   assign len_m1     = len_i - LEN_W'(1);
   assign spill_sum  = {1'b0, addr_i[LW-1:0]} + {1'b0, len_m1[LW-1:0]};
   assign take_start = start_i && (state_q == IDLE);

   // nothing is taken while the done pulse is out
   assign accept     = data_valid_i && (state_q == STREAM) && !done_q;
   assign flush_fire = (state_q == FLUSH) && !done_q;
   assign last_src   = (words_left_q == '0);
   assign last_wr    = flush_fire || (last_src && !flush_q);
   assign wr_fire    = accept || flush_fire;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (take_start) begin
               state_d = STREAM;
            end
         end
         STREAM: begin
            if (done_q) begin
               state_d = IDLE;
            end else if (accept && last_src && flush_q) begin
               state_d = FLUSH;
            end
         end
         FLUSH: begin
            if (done_q) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q      <= IDLE;
         offset_q     <= '0;
         end_lane_q   <= '0;
         waddr_q      <= '0;
         words_left_q <= '0;
         flush_q      <= 1'b0;
         first_q      <= 1'b0;
         done_q       <= 1'b0;
         mem_we_o     <= 1'b0;
      end else begin
         state_q  <= state_d;
         mem_we_o <= wr_fire;
         done_q   <= wr_fire && last_wr;
         if (take_start) begin
            offset_q     <= addr_i[LW-1:0];
            end_lane_q   <= spill_sum[LW-1:0];
            waddr_q      <= addr_i[ADDR_W-1:LW];
            words_left_q <= len_m1[LEN_W-1:LW];
            flush_q      <= spill_sum[LW];
            first_q      <= 1'b1;
         end else if (wr_fire) begin
            waddr_q <= waddr_q + WA_W'(1);
            first_q <= 1'b0;
            if (accept && !last_src) begin
               words_left_q <= words_left_q - WC_W'(1);
            end
         end
      end
   end

   // write port payload
   always_ff @(posedge clk_i) begin
      if (wr_fire) begin
         mem_addr_o <= waddr_q;
         mem_strb_o <= strb;
         mem_data_o <= realigned;
      end
   end

   assign done_o = done_q;
   assign busy_o = (state_q != IDLE);

   byte_realign #(
      .DATA_W (DATA_W)
   ) u_realign (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .offset_i (offset_q),
      .data_i   (data_i),
      .accept_i (accept),
      .data_o   (realigned)
   );

   wr_strobe_gen #(
      .DATA_W (DATA_W)
   ) u_strb (
      .first_i      (first_q),
      .last_i       (last_wr),
      .start_lane_i (offset_q),
      .end_lane_i   (end_lane_q),
      .strb_o       (strb)
   );

endmodule

`default_nettype wire

// ==== hw/burst_write_unit.sv ====
`default_nettype none

module burst_write_unit #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 16,
   parameter int LEN_W  = 10
) (
   input  wire                                          clk_i,
   input  wire                                          rst_i,
   input  wire                                          start_i,
   input  wire  [ADDR_W-1:0]                            addr_i,
   input  wire  [LEN_W-1:0]                             len_i,
   input  wire                                          data_valid_i,
   input  wire  [DATA_W-1:0]                            data_i,
   output logic                                         mem_we_o,
   output logic [ADDR_W-burst_pkg::lanes_w(DATA_W)-1:0] mem_addr_o,
   output logic [DATA_W/8-1:0]                          mem_strb_o,
   output logic [DATA_W-1:0]                            mem_data_o,
   output logic                                         busy_o,
   output logic                                         done_o
);

   // memory side with at most one write per cycle
   wire                                          ctrl_we;
   wire [ADDR_W-burst_pkg::lanes_w(DATA_W)-1:0] ctrl_addr;
   wire [DATA_W/8-1:0]                           ctrl_strb;
   wire [DATA_W-1:0]                             ctrl_data;

   // burst status
   wire                                          ctrl_busy;
   wire                                          ctrl_done;

   burst_write_ctrl #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W),
      .LEN_W  (LEN_W)
   ) u_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start_i),
      .addr_i       (addr_i),
      .len_i        (len_i),
      .data_valid_i (data_valid_i),
      .data_i       (data_i),
      .mem_we_o     (ctrl_we),
      .mem_addr_o   (ctrl_addr),
      .mem_strb_o   (ctrl_strb),
      .mem_data_o   (ctrl_data),
      .busy_o       (ctrl_busy),
      .done_o       (ctrl_done)
   );

   assign mem_we_o   = ctrl_we;
   assign mem_addr_o = ctrl_addr;
   assign mem_strb_o = ctrl_strb;
   assign mem_data_o = ctrl_data;
   assign busy_o     = ctrl_busy;
   assign done_o     = ctrl_done;

endmodule

`default_nettype wire

// ==== sim/burst_write_props.sv ====
`default_nettype none

module burst_write_props #(
   parameter int DATA_W = 32
) (
   input wire                       clk_i,
   input wire                       rst_i,
   input wire burst_pkg::wr_state_t state_i,
   input wire                       mem_we_i,
   input wire [DATA_W/8-1:0]        mem_strb_i,
   input wire                       busy_i,
   input wire                       done_i
);

   timeunit 1ns;
   timeprecision 100ps;

   import burst_pkg::*;

   int unsigned fail_cnt;  // failed assertions so far

   initial fail_cnt = 0;

   a_no_we_in_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_we_i |-> (state_i != IDLE))
      else begin
         $error("memory write while controller idle");
         fail_cnt++;
      end

   a_done_with_we: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i |-> mem_we_i)
      else begin
         $error("done pulse without a memory write");
         fail_cnt++;
      end

   a_strb_nonzero: assert property (@(posedge clk_i) disable iff (rst_i)
      mem_we_i |-> (mem_strb_i != '0))
      else begin
         $error("memory write with empty strobe");
         fail_cnt++;
      end

   a_busy_after_done: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i |=> !busy_i)
      else begin
         $error("busy still high the cycle after done");
         fail_cnt++;
      end

endmodule

`default_nettype wire

// ==== sim/tb_burst_write.sv ====
`default_nettype none

module tb_burst_write;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DATA_W = 32;
   localparam int ADDR_W = 16;
   localparam int LEN_W  = 10;
   localparam int B      = DATA_W / 8;
   localparam int LW     = $clog2(B);
   localparam int WA_W   = ADDR_W - LW;
   localparam int MAX_WR = 32;

   logic              clk_i;
   logic              rst_i;
   logic              start_i;
   logic [ADDR_W-1:0] addr_i;
   logic [LEN_W-1:0]  len_i;
   logic              data_valid_i;
   logic [DATA_W-1:0] data_i;
   logic              mem_we_o;
   logic [WA_W-1:0]   mem_addr_o;
   logic [B-1:0]      mem_strb_o;
   logic [DATA_W-1:0] mem_data_o;
   logic              busy_o;
   logic              done_o;

   logic [31:0]       lfsr_q;
   logic [7:0]        ref_mem [2**ADDR_W];
   logic [7:0]        dut_mem [2**ADDR_W];
   logic [7:0]        src     [MAX_WR*B];  // source bytes of the current burst
   logic [WA_W-1:0]   wr_addr [MAX_WR];
   logic [B-1:0]      wr_strb [MAX_WR];
   logic [DATA_W-1:0] wr_data [MAX_WR];
   int                n_src;
   int                n_wr;
   int                next_j;                // next expected write
   logic              due;                   // write expected at next sample
   logic              busy_exp;
   logic              done_seen;

   initial clk_i = 1'b0;
   always #10 clk_i = ~clk_i;

   burst_write_unit #(
      .DATA_W (DATA_W),
      .ADDR_W (ADDR_W),
      .LEN_W  (LEN_W)
   ) dut0 (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_i      (start_i),
      .addr_i       (addr_i),
      .len_i        (len_i),
      .data_valid_i (data_valid_i),
      .data_i       (data_i),
      .mem_we_o     (mem_we_o),
      .mem_addr_o   (mem_addr_o),
      .mem_strb_o   (mem_strb_o),
      .mem_data_o   (mem_data_o),
      .busy_o       (busy_o),
      .done_o       (done_o)
   );

   bind burst_write_ctrl burst_write_props #(
      .DATA_W (DATA_W)
   ) u_props (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .state_i    (state_q),
      .mem_we_i   (mem_we_o),
      .mem_strb_i (mem_strb_o),
      .busy_i     (busy_o),
      .done_i     (done_o)
   );

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         stop_run($sformatf("error at %0t: %s expected %b got %b", $time, name, exp, act));
      end
   endtask

   task automatic check_write(input logic [WA_W-1:0] exp_addr, input logic [B-1:0] exp_strb,
                              input logic [DATA_W-1:0] exp_data);
      if (mem_addr_o !== exp_addr) begin
         stop_run($sformatf("error at %0t: mem_addr_o expected %h got %h",
                            $time, exp_addr, mem_addr_o));
      end
      if (mem_strb_o !== exp_strb) begin
         stop_run($sformatf("error at %0t: mem_strb_o expected %b got %b",
                            $time, exp_strb, mem_strb_o));
      end
      for (int l = 0; l < B; l++) begin
         if (exp_strb[l] && (mem_data_o[8*l +: 8] !== exp_data[8*l +: 8])) begin
            stop_run($sformatf("error at %0t: mem_data_o lane %0d expected %h got %h",
                               $time, l, exp_data[8*l +: 8], mem_data_o[8*l +: 8]));
         end
      end
   endtask

   // one clock with outputs checked 2 ns after the edge
   task automatic sample;
      @(posedge clk_i);
      #2;
      if (dut0.u_ctrl.u_props.fail_cnt != 0) begin
         stop_run("a bound assertion on the controller failed");
      end
      check_flag("busy_o", busy_o, busy_exp);
      check_flag("mem_we_o", mem_we_o, due);
      if (due) begin
         check_write(wr_addr[next_j], wr_strb[next_j], wr_data[next_j]);
         check_flag("done_o", done_o, next_j == n_wr - 1);
         for (int l = 0; l < B; l++) begin
            if (mem_strb_o[l]) begin
               dut_mem[{mem_addr_o, LW'(l)}] = mem_data_o[8*l +: 8];
            end
         end
         next_j++;
         due = (next_j == n_src) && (n_wr > n_src);  // flush write follows
         if (next_j == n_wr) begin
            done_seen = 1'b1;
            busy_exp  = 1'b0;
         end
      end else begin
         check_flag("done_o", done_o, 1'b0);
      end
   endtask

   task automatic drive_noise(input logic noise, input logic with_valid);
      logic [31:0] r;
      draw(ADDR_W + 2, r);
      start_i      = noise & r[0];
      data_valid_i = noise & with_valid & r[1];
      addr_i       = r[ADDR_W+1:2];
   endtask

   task automatic run_burst(input logic [ADDR_W-1:0] a, input int len, input logic gapped,
                            input logic noise);
      int o;
      int k;
      int gap;
      int tmo;
      logic [31:0] r;
      o     = int'(a[LW-1:0]);
      n_src = (len + B - 1) / B;
      n_wr  = (o + len + B - 1) / B;
      for (int w = 0; w < n_src; w++) begin
         draw(DATA_W, r);
         for (int l = 0; l < B; l++) begin
            src[w*B + l] = r[8*l +: 8];
         end
      end
      // memory byte a+k receives source byte k
      for (int j = 0; j < n_wr; j++) begin
         wr_addr[j] = WA_W'(int'(a[ADDR_W-1:LW]) + j);
         wr_strb[j] = '0;
         wr_data[j] = '0;
         for (int l = 0; l < B; l++) begin
            k = j*B + l - o;
            if (k >= 0 && k < len) begin
               wr_strb[j][l]        = 1'b1;
               wr_data[j][8*l +: 8] = src[k];
            end
         end
      end
      for (int i = 0; i < len; i++) begin
         ref_mem[ADDR_W'(int'(a) + i)] = src[i];
      end
      next_j    = 0;
      done_seen = 1'b0;
      due       = 1'b0;
      start_i   = 1'b1;
      addr_i    = a;
      len_i     = LEN_W'(len);
      busy_exp  = 1'b1;
      sample();
      for (int w = 0; w < n_src; w++) begin
         draw(2, r);
         gap = gapped ? int'(r[1:0]) : 0;
         for (int g = 0; g < gap; g++) begin
            drive_noise(noise, 1'b0);
            sample();
         end
         drive_noise(noise, 1'b0);
         data_valid_i = 1'b1;
         for (int l = 0; l < B; l++) begin
            data_i[8*l +: 8] = src[w*B + l];
         end
         due = 1'b1;
         sample();
      end
      tmo = 0;
      while (!done_seen) begin
         drive_noise(noise, 1'b1);
         sample();
         tmo++;
         if (tmo > 8) begin
            stop_run("timeout: burst never finished with done_o");
         end
      end
      drive_noise(noise, 1'b1);  // lands while the controller returns to idle
      sample();
      start_i      = 1'b0;
      data_valid_i = 1'b0;
   endtask

   initial begin
      logic [31:0] r;
      int o;
      int bad;
      lfsr_q       = 32'h8d97;
      rst_i        = 1'b1;
      start_i      = 1'b0;
      addr_i       = '0;
      len_i        = '0;
      data_valid_i = 1'b0;
      data_i       = '0;
      due          = 1'b0;
      busy_exp     = 1'b0;
      done_seen    = 1'b0;
      next_j       = 0;
      n_src        = 0;
      n_wr         = 0;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         ref_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
         dut_mem[a] = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;
      end
      repeat (10) @(posedge clk_i);
      #2;
      rst_i = 1'b0;
      repeat (20) sample();  // idle with nothing moving
      for (int i = 0; i < 20; i++) begin
         draw(ADDR_W + 6, r);
         run_burst({r[ADDR_W-1:LW], LW'(0)}, 1 + int'(r[ADDR_W+5:ADDR_W]), 1'b0, 1'b0);
      end
      for (int i = 0; i < 40; i++) begin
         draw(ADDR_W + 6, r);
         run_burst(r[ADDR_W-1:0], 1 + int'(r[ADDR_W+5:ADDR_W]), 1'b0, 1'b0);
      end
      for (int i = 0; i < 40; i++) begin
         draw(ADDR_W + 6, r);
         run_burst(r[ADDR_W-1:0], 1 + int'(r[ADDR_W+5:ADDR_W]), 1'b1, 1'b0);
      end
      // start and end lane inside one word
      for (int i = 0; i < 20; i++) begin
         draw(ADDR_W + LW, r);
         o = int'(r[LW-1:0]);
         run_burst(r[ADDR_W-1:0], 1 + int'(r[ADDR_W+LW-1:ADDR_W]) % (B - o), 1'b1, 1'b0);
      end
      for (int i = 0; i < 30; i++) begin
         draw(ADDR_W + 6, r);
         run_burst(r[ADDR_W-1:0], 1 + int'(r[ADDR_W+5:ADDR_W]), 1'b1, 1'b1);
      end
      bad = -1;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         if (bad < 0 && dut_mem[a] !== ref_mem[a]) begin
            bad = a;
         end
      end
      if (bad >= 0) begin
         stop_run($sformatf("error at %0t: memory byte %h expected %h got %h",
                            $time, bad, ref_mem[bad], dut_mem[bad]));
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== build.f ====
hw/burst_pkg.sv
hw/byte_realign.sv
hw/wr_strobe_gen.sv
hw/burst_write_ctrl.sv
hw/burst_write_unit.sv
sim/burst_write_props.sv
sim/tb_burst_write.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_burst_write
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
